/* design/trace_pkg.sv */
package trace_pkg;

  // Monitored cores on the shared trace stream
  localparam int NUM_CORES = 4;
  localparam int CORE_W    = $clog2(NUM_CORES);

  localparam int WORD_W    = 32;
  localparam int REG_IDX_W = 5;
  localparam int KIND_W    = 2;

  typedef logic [CORE_W-1:0]    core_id_t;
  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [15:0]          nop_code_t;
  typedef logic [KIND_W-1:0]    evt_kind_t;

  // Register that carries the no-op argument
  localparam reg_idx_t R3_IDX = 5'd3;

  // Top byte of l.nop, code sits in the low half of the instruction
  localparam logic [7:0] NOP_OPCODE = 8'h15;

  localparam nop_code_t NOP_EXIT   = 16'h0001;
  localparam nop_code_t NOP_REPORT = 16'h0002;
  localparam nop_code_t NOP_PUTC   = 16'h0004;

  // Event kinds on the output stream
  localparam evt_kind_t EVT_EXIT   = 2'd0;
  localparam evt_kind_t EVT_REPORT = 2'd1;
  localparam evt_kind_t EVT_PUTC   = 2'd2;

endpackage

/* design/trace_ingress.sv */
`timescale 1ns/10ps

module trace_ingress (
  input  logic              clk,
  input  logic              arst_n_i,
  // Trace record stream from the cores
  input  logic              tr_valid_i,
  output logic              tr_ready_o,
  input  trace_pkg::core_id_t tr_core_i,
  input  trace_pkg::word_t  tr_pc_i,
  input  trace_pkg::word_t  tr_insn_i,
  input  logic              tr_wben_i,
  input  trace_pkg::reg_idx_t tr_wbreg_i,
  input  trace_pkg::word_t  tr_wbdata_i,
  // Registered records towards the r3 tracker
  output logic              ig_valid_o,
  input  logic              ig_ready_i,
  output trace_pkg::core_id_t ig_core_o,
  output trace_pkg::word_t  ig_pc_o,
  output trace_pkg::word_t  ig_insn_o,
  output logic              ig_wben_o,
  output trace_pkg::reg_idx_t ig_wbreg_o,
  output trace_pkg::word_t  ig_wbdata_o
);

  logic main_valid_q;
  logic skid_valid_q;
  logic tr_fire;
  logic main_free;

  // Skid copy of one record, loaded when the main register stalls
  trace_pkg::core_id_t skid_core_q;
  trace_pkg::word_t    skid_pc_q;
  trace_pkg::word_t    skid_insn_q;
  logic                skid_wben_q;
  trace_pkg::reg_idx_t skid_wbreg_q;
  trace_pkg::word_t    skid_wbdata_q;

  // Ready only looks at the skid slot, never at downstream ready
  assign tr_ready_o = ~skid_valid_q;
  assign tr_fire    = tr_valid_i & tr_ready_o;
  assign main_free  = ~main_valid_q | ig_ready_i;
  assign ig_valid_o = main_valid_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (main_free) begin
      // Skid slot drains first to keep order
      main_valid_q <= skid_valid_q | tr_fire;
      skid_valid_q <= 1'b0;
    end else if (tr_fire) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free && skid_valid_q) begin
      ig_core_o   <= skid_core_q;
      ig_pc_o     <= skid_pc_q;
      ig_insn_o   <= skid_insn_q;
      ig_wben_o   <= skid_wben_q;
      ig_wbreg_o  <= skid_wbreg_q;
      ig_wbdata_o <= skid_wbdata_q;
    end else if (main_free && tr_fire) begin
      ig_core_o   <= tr_core_i;
      ig_pc_o     <= tr_pc_i;
      ig_insn_o   <= tr_insn_i;
      ig_wben_o   <= tr_wben_i;
      ig_wbreg_o  <= tr_wbreg_i;
      ig_wbdata_o <= tr_wbdata_i;
    end
    if (!main_free && tr_fire) begin
      skid_core_q   <= tr_core_i;
      skid_pc_q     <= tr_pc_i;
      skid_insn_q   <= tr_insn_i;
      skid_wben_q   <= tr_wben_i;
      skid_wbreg_q  <= tr_wbreg_i;
      skid_wbdata_q <= tr_wbdata_i;
    end
  end

endmodule

/* design/r3_tracker.sv */
`timescale 1ns/10ps

module r3_tracker (
  input  logic              clk,
  input  logic              arst_n_i,
  // Records from the ingress stage
  input  logic              ig_valid_i,
  output logic              ig_ready_o,
  input  trace_pkg::core_id_t ig_core_i,
  input  trace_pkg::word_t  ig_pc_i,
  input  trace_pkg::word_t  ig_insn_i,
  input  logic              ig_wben_i,
  input  trace_pkg::reg_idx_t ig_wbreg_i,
  input  trace_pkg::word_t  ig_wbdata_i,
  // Records with the r3 value seen before their own writeback
  output logic              tk_valid_o,
  input  logic              tk_ready_i,
  output trace_pkg::core_id_t tk_core_o,
  output trace_pkg::word_t  tk_pc_o,
  output trace_pkg::word_t  tk_insn_o,
  output trace_pkg::word_t  tk_r3_o
);

  trace_pkg::word_t shadow_q [trace_pkg::NUM_CORES];

  logic tk_valid_q;
  logic ig_fire;
  logic r3_write;

  assign ig_ready_o = ~tk_valid_q | tk_ready_i;
  assign ig_fire    = ig_valid_i & ig_ready_o;
  assign tk_valid_o = tk_valid_q;

  // Writeback hits r3 of the record's own core
  assign r3_write = ig_fire & ig_wben_i & (ig_wbreg_i == trace_pkg::R3_IDX);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tk_valid_q <= 1'b0;
    end else if (ig_ready_o) begin
      tk_valid_q <= ig_valid_i;
    end
  end

  // Shadows start from zero like the core register file
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < trace_pkg::NUM_CORES; i++) begin
        shadow_q[i] <= '0;
      end
    end else if (r3_write) begin
      shadow_q[ig_core_i] <= ig_wbdata_i;
    end
  end

  // Old shadow value travels with the record
  always_ff @(posedge clk) begin
    if (ig_fire) begin
      tk_core_o <= ig_core_i;
      tk_pc_o   <= ig_pc_i;
      tk_insn_o <= ig_insn_i;
      tk_r3_o   <= shadow_q[ig_core_i];
    end
  end

endmodule

/* design/nop_classifier.sv */
`timescale 1ns/10ps

module nop_classifier (
  input  logic                 clk,
  input  logic                 arst_n_i,
  // Records with r3 attached
  input  logic                 tk_valid_i,
  output logic                 tk_ready_o,
  input  trace_pkg::core_id_t  tk_core_i,
  input  trace_pkg::word_t     tk_pc_i,
  input  trace_pkg::word_t     tk_insn_i,
  input  trace_pkg::word_t     tk_r3_i,
  // Classified control no-ops
  output logic                 cl_valid_o,
  input  logic                 cl_ready_i,
  output trace_pkg::evt_kind_t cl_kind_o,
  output trace_pkg::core_id_t  cl_core_o,
  output trace_pkg::word_t     cl_value_o,
  output trace_pkg::word_t     cl_pc_o
);

  logic                 cl_valid_q;
  logic                 tk_fire;
  logic                 is_nop;
  logic                 is_event;
  trace_pkg::nop_code_t nop_code;
  trace_pkg::evt_kind_t kind;
  trace_pkg::word_t     value;

  assign tk_ready_o = ~cl_valid_q | cl_ready_i;
  assign tk_fire    = tk_valid_i & tk_ready_o;
  assign cl_valid_o = cl_valid_q;

  assign is_nop   = (tk_insn_i[31:24] == trace_pkg::NOP_OPCODE);
  assign nop_code = tk_insn_i[15:0];

  // Map the no-op code to an event kind
  always_comb begin
    kind     = trace_pkg::EVT_EXIT;
    is_event = 1'b0;
    if (is_nop) begin
      case (nop_code)
        trace_pkg::NOP_EXIT: begin
          kind     = trace_pkg::EVT_EXIT;
          is_event = 1'b1;
        end
        trace_pkg::NOP_REPORT: begin
          kind     = trace_pkg::EVT_REPORT;
          is_event = 1'b1;
        end
        trace_pkg::NOP_PUTC: begin
          kind     = trace_pkg::EVT_PUTC;
          is_event = 1'b1;
        end
        default: begin
          kind     = trace_pkg::EVT_EXIT;
          is_event = 1'b0;
        end
      endcase
    end
  end

  // Putc carries only the character byte
  assign value = (kind == trace_pkg::EVT_PUTC) ? {24'h0, tk_r3_i[7:0]} : tk_r3_i;

  // Non-event records are consumed here and leave the register empty
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cl_valid_q <= 1'b0;
    end else if (tk_ready_o) begin
      cl_valid_q <= tk_valid_i & is_event;
    end
  end

  always_ff @(posedge clk) begin
    if (tk_fire && is_event) begin
      cl_kind_o  <= kind;
      cl_core_o  <= tk_core_i;
      cl_value_o <= value;
      cl_pc_o    <= tk_pc_i;
    end
  end

endmodule

/* design/termination_tracker.sv */
`timescale 1ns/10ps

module termination_tracker (
  input  logic                 clk,
  input  logic                 arst_n_i,
  // Events from the classifier
  input  logic                 cl_valid_i,
  output logic                 cl_ready_o,
  input  trace_pkg::evt_kind_t cl_kind_i,
  input  trace_pkg::core_id_t  cl_core_i,
  input  trace_pkg::word_t     cl_value_i,
  input  trace_pkg::word_t     cl_pc_i,
  // Event stream to the consumer
  output logic                 evt_valid_o,
  input  logic                 evt_ready_i,
  output trace_pkg::evt_kind_t evt_kind_o,
  output trace_pkg::core_id_t  evt_core_o,
  output trace_pkg::word_t     evt_value_o,
  output trace_pkg::word_t     evt_pc_o,
  // Termination status
  output logic [trace_pkg::NUM_CORES-1:0] exit_mask_o,
  output logic                 done_o
);

  logic                          evt_valid_q;
  logic                          cl_fire;
  logic                          exit_accept;
  logic [trace_pkg::NUM_CORES-1:0] exit_mask_d;

  assign cl_ready_o  = ~evt_valid_q | evt_ready_i;
  assign cl_fire     = cl_valid_i & cl_ready_o;
  assign evt_valid_o = evt_valid_q;

  // Exit counts only once the consumer has taken it
  assign exit_accept = evt_valid_q & evt_ready_i & (evt_kind_o == trace_pkg::EVT_EXIT);

  always_comb begin
    exit_mask_d = exit_mask_o;
    if (exit_accept) begin
      exit_mask_d[evt_core_o] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_valid_q <= 1'b0;
    end else if (cl_ready_o) begin
      evt_valid_q <= cl_valid_i;
    end
  end

  // Done is sticky and tracks the next mask so both change together
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exit_mask_o <= '0;
      done_o      <= 1'b0;
    end else begin
      exit_mask_o <= exit_mask_d;
      done_o      <= done_o | (&exit_mask_d);
    end
  end

  always_ff @(posedge clk) begin
    if (cl_fire) begin
      evt_kind_o  <= cl_kind_i;
      evt_core_o  <= cl_core_i;
      evt_value_o <= cl_value_i;
      evt_pc_o    <= cl_pc_i;
    end
  end

endmodule

/* design/trace_monitor_top.sv */
`timescale 1ns/10ps

module trace_monitor_top (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 tr_valid_i,
  output logic                 tr_ready_o,
  input  trace_pkg::core_id_t  tr_core_i,
  input  trace_pkg::word_t     tr_pc_i,
  input  trace_pkg::word_t     tr_insn_i,
  input  logic                 tr_wben_i,
  input  trace_pkg::reg_idx_t  tr_wbreg_i,
  input  trace_pkg::word_t     tr_wbdata_i,
  output logic                 evt_valid_o,
  input  logic                 evt_ready_i,
  output trace_pkg::evt_kind_t evt_kind_o,
  output trace_pkg::core_id_t  evt_core_o,
  output trace_pkg::word_t     evt_value_o,
  output trace_pkg::word_t     evt_pc_o,
  output logic [trace_pkg::NUM_CORES-1:0] exit_mask_o,
  output logic                 done_o
);

  // Ingress to tracker
  logic                 ig_valid;
  logic                 ig_ready;
  trace_pkg::core_id_t  ig_core;
  trace_pkg::word_t     ig_pc;
  trace_pkg::word_t     ig_insn;
  logic                 ig_wben;
  trace_pkg::reg_idx_t  ig_wbreg;
  trace_pkg::word_t     ig_wbdata;

  // Tracker to classifier
  logic                 tk_valid;
  logic                 tk_ready;
  trace_pkg::core_id_t  tk_core;
  trace_pkg::word_t     tk_pc;
  trace_pkg::word_t     tk_insn;
  trace_pkg::word_t     tk_r3;

  // Classifier to termination tracker
  logic                 cl_valid;
  logic                 cl_ready;
  trace_pkg::evt_kind_t cl_kind;
  trace_pkg::core_id_t  cl_core;
  trace_pkg::word_t     cl_value;
  trace_pkg::word_t     cl_pc;

  trace_ingress u_ingress (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .tr_valid_i  (tr_valid_i),
    .tr_ready_o  (tr_ready_o),
    .tr_core_i   (tr_core_i),
    .tr_pc_i     (tr_pc_i),
    .tr_insn_i   (tr_insn_i),
    .tr_wben_i   (tr_wben_i),
    .tr_wbreg_i  (tr_wbreg_i),
    .tr_wbdata_i (tr_wbdata_i),
    .ig_valid_o  (ig_valid),
    .ig_ready_i  (ig_ready),
    .ig_core_o   (ig_core),
    .ig_pc_o     (ig_pc),
    .ig_insn_o   (ig_insn),
    .ig_wben_o   (ig_wben),
    .ig_wbreg_o  (ig_wbreg),
    .ig_wbdata_o (ig_wbdata)
  );

  r3_tracker u_r3_tracker (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .ig_valid_i  (ig_valid),
    .ig_ready_o  (ig_ready),
    .ig_core_i   (ig_core),
    .ig_pc_i     (ig_pc),
    .ig_insn_i   (ig_insn),
    .ig_wben_i   (ig_wben),
    .ig_wbreg_i  (ig_wbreg),
    .ig_wbdata_i (ig_wbdata),
    .tk_valid_o  (tk_valid),
    .tk_ready_i  (tk_ready),
    .tk_core_o   (tk_core),
    .tk_pc_o     (tk_pc),
    .tk_insn_o   (tk_insn),
    .tk_r3_o     (tk_r3)
  );

  nop_classifier u_classifier (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .tk_valid_i (tk_valid),
    .tk_ready_o (tk_ready),
    .tk_core_i  (tk_core),
    .tk_pc_i    (tk_pc),
    .tk_insn_i  (tk_insn),
    .tk_r3_i    (tk_r3),
    .cl_valid_o (cl_valid),
    .cl_ready_i (cl_ready),
    .cl_kind_o  (cl_kind),
    .cl_core_o  (cl_core),
    .cl_value_o (cl_value),
    .cl_pc_o    (cl_pc)
  );

  termination_tracker u_term (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .cl_valid_i  (cl_valid),
    .cl_ready_o  (cl_ready),
    .cl_kind_i   (cl_kind),
    .cl_core_i   (cl_core),
    .cl_value_i  (cl_value),
    .cl_pc_i     (cl_pc),
    .evt_valid_o (evt_valid_o),
    .evt_ready_i (evt_ready_i),
    .evt_kind_o  (evt_kind_o),
    .evt_core_o  (evt_core_o),
    .evt_value_o (evt_value_o),
    .evt_pc_o    (evt_pc_o),
    .exit_mask_o (exit_mask_o),
    .done_o      (done_o)
  );

endmodule

/* tests/trace_monitor_props.sv */
`timescale 1ns/10ps

module trace_monitor_props (
  input logic                            clk,
  input logic                            arst_n_i,
  input logic                            tr_valid_i,
  input logic                            tr_ready_o,
  input trace_pkg::core_id_t             tr_core_i,
  input trace_pkg::word_t                tr_pc_i,
  input trace_pkg::word_t                tr_insn_i,
  input logic                            tr_wben_i,
  input trace_pkg::reg_idx_t             tr_wbreg_i,
  input trace_pkg::word_t                tr_wbdata_i,
  input logic                            evt_valid_o,
  input logic                            evt_ready_i,
  input trace_pkg::evt_kind_t            evt_kind_o,
  input trace_pkg::core_id_t             evt_core_o,
  input trace_pkg::word_t                evt_value_o,
  input trace_pkg::word_t                evt_pc_o,
  input logic [trace_pkg::NUM_CORES-1:0] exit_mask_o,
  input logic                            done_o
);

  // Number of failed checks
  int violations = 0;

  // Producer side holds the record until it is taken
  tr_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      tr_valid_i && !tr_ready_o |=> tr_valid_i &&
        $stable({tr_core_i, tr_pc_i, tr_insn_i, tr_wben_i, tr_wbreg_i, tr_wbdata_i}))
    else begin
      $error("tr record changed or dropped while stalled");
      violations++;
    end

  evt_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      evt_valid_o && !evt_ready_i |=> evt_valid_o &&
        $stable({evt_kind_o, evt_core_o, evt_value_o, evt_pc_o}))
    else begin
      $error("evt record changed or dropped while stalled");
      violations++;
    end

  // First edge out of reset sees an idle, empty monitor
  reset_idle: assert property (@(posedge clk)
      $rose(arst_n_i) |-> !evt_valid_o && !done_o && exit_mask_o == '0 && tr_ready_o)
    else begin
      $error("outputs not idle after reset");
      violations++;
    end

  done_sticky: assert property (@(posedge clk) disable iff (!arst_n_i)
      done_o |=> done_o)
    else begin
      $error("done_o fell without reset");
      violations++;
    end

  done_full: assert property (@(posedge clk) disable iff (!arst_n_i)
      done_o == (&exit_mask_o))
    else begin
      $error("done_o disagrees with exit_mask_o");
      violations++;
    end

endmodule

bind trace_monitor_top trace_monitor_props u_props (.*);

/* tests/tb_trace_monitor.sv */
`timescale 1ns/10ps

module tb_trace_monitor;

  localparam int EVT_W            = 68;
  localparam int RAND_RECORDS     = 200;
  // Records sent by tests 1, 2, 3 and 5
  localparam int DIRECTED_RECORDS = 34;
  localparam int CYCLE_LIMIT      = 2 * (RAND_RECORDS + DIRECTED_RECORDS) + 200;
  localparam logic [31:0] LFSR_SEED = 32'h6f043c7c;

  logic                            clk;
  logic                            arst_n_i;
  logic                            tr_valid_i;
  logic                            tr_ready_o;
  trace_pkg::core_id_t             tr_core_i;
  trace_pkg::word_t                tr_pc_i;
  trace_pkg::word_t                tr_insn_i;
  logic                            tr_wben_i;
  trace_pkg::reg_idx_t             tr_wbreg_i;
  trace_pkg::word_t                tr_wbdata_i;
  logic                            evt_valid_o;
  logic                            evt_ready_i;
  trace_pkg::evt_kind_t            evt_kind_o;
  trace_pkg::core_id_t             evt_core_o;
  trace_pkg::word_t                evt_value_o;
  trace_pkg::word_t                evt_pc_o;
  logic [trace_pkg::NUM_CORES-1:0] exit_mask_o;
  logic                            done_o;

  // Reference model state, events packed as {kind, core, value, pc}
  logic [EVT_W-1:0]                exp_q[$];
  logic [EVT_W-1:0]                exp_head;
  logic [EVT_W-1:0]                popped;
  logic                            exp_avail;
  trace_pkg::word_t                r3_model [trace_pkg::NUM_CORES];
  logic [trace_pkg::NUM_CORES-1:0] mask_model;

  logic [31:0] stim_lfsr;
  logic [31:0] bp_lfsr;
  logic        bp_bit;
  logic        bp_enable;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_passed;
  int          cycle_count;

  trace_monitor_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      bits = {bits[30:0], stim_lfsr[0]};
    end
    return bits;
  endfunction

  function automatic trace_pkg::word_t nop_insn(input logic [15:0] code);
    return {trace_pkg::NOP_OPCODE, 8'h00, code};
  endfunction

  // Ordinary instruction with random operand bits
  function automatic trace_pkg::word_t alu_insn();
    logic [31:0] bits;
    bits = rand_bits(24);
    return {8'h9c, bits[23:0]};
  endfunction

  function automatic int error_total();
    return errors + DUT.u_props.violations;
  endfunction

  // r3 is read before the record's own writeback
  task automatic model_record(input trace_pkg::core_id_t core, input trace_pkg::word_t pc,
                              input trace_pkg::word_t insn, input logic wben,
                              input trace_pkg::reg_idx_t wbreg, input trace_pkg::word_t wbdata);
    trace_pkg::word_t r3;
    r3 = r3_model[core];
    if (insn[31:24] == trace_pkg::NOP_OPCODE) begin
      case (insn[15:0])
        trace_pkg::NOP_EXIT:   exp_q.push_back({trace_pkg::EVT_EXIT, core, r3, pc});
        trace_pkg::NOP_REPORT: exp_q.push_back({trace_pkg::EVT_REPORT, core, r3, pc});
        trace_pkg::NOP_PUTC:   exp_q.push_back({trace_pkg::EVT_PUTC, core, {24'h0, r3[7:0]}, pc});
        default: ;
      endcase
    end
    if (wben && wbreg == trace_pkg::R3_IDX) begin
      r3_model[core] = wbdata;
    end
  endtask

  always @(posedge clk) begin
    if (!arst_n_i) begin
      exp_q.delete();
      mask_model = '0;
      for (int c = 0; c < trace_pkg::NUM_CORES; c++) begin
        r3_model[c] = '0;
      end
    end else begin
      if (evt_valid_o && evt_ready_i && exp_q.size() > 0) begin
        popped = exp_q.pop_front();
        if (popped[67:66] == trace_pkg::EVT_EXIT) begin
          mask_model[popped[65:64]] = 1'b1;
        end
      end
      if (tr_valid_i && tr_ready_o) begin
        model_record(tr_core_i, tr_pc_i, tr_insn_i, tr_wben_i, tr_wbreg_i, tr_wbdata_i);
      end
    end
    exp_avail = (exp_q.size() > 0);
    exp_head  = exp_avail ? exp_q[0] : '0;
  end

  evt_check: assert property (@(posedge clk) disable iff (!arst_n_i)
      evt_valid_o && evt_ready_i |->
        exp_avail && {evt_kind_o, evt_core_o, evt_value_o, evt_pc_o} == exp_head)
    else begin
      $display("[ERROR] %0t: expected kind %0d core %0d value %h pc %h", $time,
               $sampled(exp_head[67:66]), $sampled(exp_head[65:64]),
               $sampled(exp_head[63:32]), $sampled(exp_head[31:0]));
      $display("[ERROR] %0t: got kind %0d core %0d value %h pc %h", $time,
               $sampled(evt_kind_o), $sampled(evt_core_o),
               $sampled(evt_value_o), $sampled(evt_pc_o));
      errors++;
    end

  mask_check: assert property (@(posedge clk) disable iff (!arst_n_i)
      exit_mask_o == mask_model)
    else begin
      $display("[ERROR] %0t: exit_mask_o expected %b got %b", $time,
               $sampled(mask_model), $sampled(exit_mask_o));
      errors++;
    end

  done_check: assert property (@(posedge clk) disable iff (!arst_n_i)
      done_o == (&mask_model))
    else begin
      $display("[ERROR] %0t: done_o expected %b got %b", $time,
               $sampled(&mask_model), $sampled(done_o));
      errors++;
    end

  // Consumer ready is high three cycles out of four under back-pressure
  always @(negedge clk) begin
    if (bp_enable) begin
      bp_lfsr = lfsr_next(bp_lfsr);
      bp_bit  = bp_lfsr[0];
      bp_lfsr = lfsr_next(bp_lfsr);
      evt_ready_i = bp_bit | bp_lfsr[0];
    end else begin
      evt_ready_i = 1'b1;
    end
  end

  // Ready only moves on the rising edge, so its value here holds for that edge
  task automatic send_record(input trace_pkg::core_id_t core, input trace_pkg::word_t pc,
                             input trace_pkg::word_t insn, input logic wben,
                             input trace_pkg::reg_idx_t wbreg, input trace_pkg::word_t wbdata);
    @(negedge clk);
    tr_valid_i  = 1'b1;
    tr_core_i   = core;
    tr_pc_i     = pc;
    tr_insn_i   = insn;
    tr_wben_i   = wben;
    tr_wbreg_i  = wbreg;
    tr_wbdata_i = wbdata;
    while (!tr_ready_o) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    tr_valid_i = 1'b0;
    @(posedge clk);
  endtask

  task automatic end_test(input string name);
    int test_errors;
    @(negedge clk);
    tr_valid_i = 1'b0;
    // Pipeline is four stages deep
    repeat (6) @(negedge clk);
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    test_errors = error_total() - errors_at_start;
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, test_errors);
    end
    errors_at_start = error_total();
  endtask

  task automatic run_random_test();
    logic [31:0]         r;
    trace_pkg::core_id_t core;
    logic                wben;
    trace_pkg::reg_idx_t wbreg;
    trace_pkg::word_t    insn;
    @(posedge clk);
    bp_enable = 1'b1;
    for (int i = 0; i < RAND_RECORDS; i++) begin
      r = rand_bits(2);
      if (r[1:0] == 2'b00) begin
        idle_cycle();
      end
      r = rand_bits(2);
      core = r[1:0];
      r = rand_bits(1);
      wben = r[0];
      r = rand_bits(6);
      wbreg = r[5] ? trace_pkg::R3_IDX : r[4:0];
      r = rand_bits(3);
      case (r[2:0])
        3'd4:    insn = nop_insn(trace_pkg::NOP_PUTC);
        3'd5:    insn = nop_insn(trace_pkg::NOP_REPORT);
        3'd6:    insn = nop_insn(16'h0008);
        default: insn = alu_insn();
      endcase
      send_record(core, 32'h4000 + i * 4, insn, wben, wbreg, rand_bits(32));
    end
    bp_enable = 1'b0;
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles waiting for events", cycle_count);
    $display("tests failed");
    $finish;
  end

  initial begin
    arst_n_i        = 1'b0;
    tr_valid_i      = 1'b0;
    tr_core_i       = '0;
    tr_pc_i         = '0;
    tr_insn_i       = '0;
    tr_wben_i       = 1'b0;
    tr_wbreg_i      = '0;
    tr_wbdata_i     = '0;
    evt_ready_i     = 1'b1;
    bp_enable       = 1'b0;
    stim_lfsr       = LFSR_SEED;
    bp_lfsr         = LFSR_SEED;
    errors          = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_passed    = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;

    send_record(2'd0, 32'h1000, 32'h9c600041, 1'b1, trace_pkg::R3_IDX, 32'h12345641);
    send_record(2'd0, 32'h1004, nop_insn(trace_pkg::NOP_PUTC), 1'b0, 5'd0, 32'h0);
    send_record(2'd0, 32'h1008, 32'h9c600042, 1'b1, trace_pkg::R3_IDX, 32'hcafe0042);
    send_record(2'd0, 32'h100c, 32'h9ca00007, 1'b1, 5'd5, 32'h77777777);
    send_record(2'd0, 32'h1010, nop_insn(trace_pkg::NOP_REPORT), 1'b0, 5'd0, 32'h0);
    end_test("putc and report values");

    // Same-record r3 writeback on the report, then a write to r7
    for (int c = 0; c < 4; c++) begin
      send_record(c, 32'h2000 + c * 4, 32'h9c600000, 1'b1, trace_pkg::R3_IDX,
                  32'h5a000000 + c * 32'h101);
    end
    for (int c = 0; c < 4; c++) begin
      send_record(c, 32'h2100 + c * 4, nop_insn(trace_pkg::NOP_REPORT), 1'b1,
                  trace_pkg::R3_IDX, 32'hdead0000 + c);
    end
    for (int c = 0; c < 4; c++) begin
      send_record(c, 32'h2200 + c * 4, 32'h9ce00000, 1'b1, 5'd7, 32'hffffffff);
    end
    for (int c = 0; c < 4; c++) begin
      send_record(c, 32'h2300 + c * 4, nop_insn(trace_pkg::NOP_PUTC), 1'b0, 5'd0, 32'h0);
    end
    end_test("interleaved cores");

    for (int i = 0; i < 4; i++) begin
      send_record(i, 32'h3000 + i * 4, alu_insn(), 1'b1, 5'd3, rand_bits(32));
    end
    send_record(2'd1, 32'h3010, nop_insn(16'h0000), 1'b0, 5'd0, 32'h0);
    send_record(2'd2, 32'h3014, nop_insn(16'h0003), 1'b0, 5'd0, 32'h0);
    send_record(2'd3, 32'h3018, nop_insn(16'h0008), 1'b1, trace_pkg::R3_IDX, 32'h1);
    send_record(2'd0, 32'h301c, nop_insn(16'h0101), 1'b0, 5'd0, 32'h0);
    end_test("non-event records");

    run_random_test();
    end_test("random back-pressure");

    send_record(2'd0, 32'h5000, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, 32'h0);
    send_record(2'd1, 32'h5004, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, 32'h0);
    send_record(2'd2, 32'h5008, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, 32'h0);
    send_record(2'd1, 32'h500c, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, 32'h0);
    send_record(2'd3, 32'h5010, nop_insn(trace_pkg::NOP_EXIT), 1'b0, 5'd0, 32'h0);
    end_test("exit and done");
    assert (done_o && exit_mask_o == 4'hf) else begin
      $display("done_o did not rise after every core exited");
      errors++;
    end

    $display("%0d tests run, %0d passed, %0d failed, %0d errors",
             tests_run, tests_passed, tests_run - tests_passed, error_total());
    if (error_total() == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
design/trace_pkg.sv
design/trace_ingress.sv
design/r3_tracker.sv
design/nop_classifier.sv
design/termination_tracker.sv
design/trace_monitor_top.sv
tests/trace_monitor_props.sv
tests/tb_trace_monitor.sv
